// ==== include/tile_ctrl_defines.svh ====
`ifndef TILE_CTRL_DEFINES_SVH
`define TILE_CTRL_DEFINES_SVH

`define N_CORES      4
`define TQ_DEPTH     8     // Also the credit count after reset
`define MEM_WORDS    256
`define MEM_AW       8
`define MEM_LATENCY  2     // Request to response, reads and writes
`define ADDR_W       16
`define DATA_W       32
`define REG_AW       8

// Target ids in host address bits 15:8
`define ID_LOCAL     8'h00
`define ID_ALL_CORES 8'hFF  // Write only

`endif

// ==== hw/tile_ctrl_pkg.sv ====
`default_nettype none

package tile_ctrl_pkg;

   typedef enum logic [3:0] {
      IDLE,
      WAIT_W,
      SEND_W,
      WAIT_MEM,
      SEND_B,
      SEND_AR,
      WAIT_R,
      SEND_R
   } bridge_state_t;

   // Bridge registers, target id 0
   typedef enum logic [7:0] {
      TASK_ENQ         = 8'h00,  // Write enqueues, read dequeues
      TASK_TTYPE       = 8'h01,
      TASK_LOCALE      = 8'h02,
      TASK_ARGS        = 8'h03,
      MEM_ADDR         = 8'h04,
      MEM_ACCESS       = 8'h05,
      CYCLE_LSB        = 8'h06,
      CYCLE_MSB        = 8'h07,
      LAST_MEM_LATENCY = 8'h08,
      PARAM_N_CORES    = 8'h09,
      DONE             = 8'h0A
   } local_reg_t;

   // Prefixed to keep clear of the local DONE
   typedef enum logic [7:0] {
      CORE_SCRATCH = 8'h00,
      CORE_CONFIG  = 8'h01,
      CORE_DONE    = 8'h02,
      CORE_INDEX   = 8'h03
   } core_reg_t;

   typedef enum logic [1:0] {
      OKAY   = 2'b00,
      SLVERR = 2'b10
   } resp_t;

   typedef struct packed {
      logic [1:0]  ttype;
      logic [31:0] locale;
      logic [31:0] args;
      logic [31:0] ts;
   } task_t;

endpackage

`default_nettype wire

// ==== hw/core_csr.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "tile_ctrl_defines.svh"

module core_csr #(
   parameter int CORE_IDX = 1
) (
   input  wire                clk,
   input  wire                rstn,
   input  wire                wvalid,
   input  wire [`REG_AW-1:0]  waddr,
   input  wire [`DATA_W-1:0]  wdata,
   input  wire                arvalid,
   input  wire [`REG_AW-1:0]  araddr,
   output logic               rvalid,
   output logic [`DATA_W-1:0] rdata,
   output logic               done
);

   import tile_ctrl_pkg::*;

   logic [`DATA_W-1:0] scratch;
   logic [`DATA_W-1:0] cfg;

   always_ff @(posedge clk) begin
      if (!rstn) begin
         scratch <= '0;
         cfg <= '0;
         done <= 1'b0;
         rvalid <= 1'b0;
      end else begin
         rvalid <= arvalid;  // Fixed one cycle read
         if (wvalid) begin
            case (core_reg_t'(waddr))
               CORE_SCRATCH: scratch <= wdata;
               CORE_CONFIG:  cfg <= wdata;
               CORE_DONE:    done <= wdata[0];
               default: ;
            endcase
         end
      end
   end

   always_ff @(posedge clk) begin
      if (arvalid) begin
         case (core_reg_t'(araddr))
            CORE_SCRATCH: rdata <= scratch;
            CORE_CONFIG:  rdata <= cfg;
            CORE_DONE:    rdata <= `DATA_W'(done);
            CORE_INDEX:   rdata <= `DATA_W'(CORE_IDX);
            default:      rdata <= '0;
         endcase
      end
   end

endmodule

`default_nettype wire

// ==== hw/scratch_mem.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "tile_ctrl_defines.svh"

module scratch_mem (
   input  wire                clk,
   input  wire                rstn,
   input  wire                req,
   input  wire                we,
   input  wire [`MEM_AW-1:0]  addr,
   input  wire [`DATA_W-1:0]  wdata,
   output logic               rvalid,
   output logic [`DATA_W-1:0] rdata
);

   logic [`DATA_W-1:0] mem [`MEM_WORDS];
   logic [`DATA_W-1:0] data_pipe [`MEM_LATENCY];
   logic [`MEM_LATENCY-1:0] vld_pipe;

   always_ff @(posedge clk) begin
      if (req && we)
         mem[addr] <= wdata;
      data_pipe[0] <= mem[addr];  // Old word on a write, unused
      for (int i = 1; i < `MEM_LATENCY; i++)
         data_pipe[i] <= data_pipe[i-1];
   end

   always_ff @(posedge clk) begin
      if (!rstn) begin
         vld_pipe <= '0;
      end else begin
         vld_pipe[0] <= req;
         for (int i = 1; i < `MEM_LATENCY; i++)
            vld_pipe[i] <= vld_pipe[i-1];
      end
   end

   assign rvalid = vld_pipe[`MEM_LATENCY-1];
   assign rdata = data_pipe[`MEM_LATENCY-1];

   // One access in flight at a time
   a_no_overlap: assert property (@(posedge clk) disable iff (!rstn)
      req |-> vld_pipe == '0);

endmodule

`default_nettype wire

// ==== hw/task_queue.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "tile_ctrl_defines.svh"

module task_queue (
   input  wire                        clk,
   input  wire                        rstn,
   input  wire                        push,
   input  wire tile_ctrl_pkg::task_t  wdata,
   input  wire                        pop,
   output logic                       credit,
   output logic                       rvalid,
   output tile_ctrl_pkg::task_t       rdata,
   output logic                       empty
);

   import tile_ctrl_pkg::*;

   localparam int PTR_W = $clog2(`TQ_DEPTH);

   task_t entries [`TQ_DEPTH];

   logic [PTR_W-1:0] wr_ptr;
   logic [PTR_W-1:0] rd_ptr;
   logic [PTR_W:0] count;
   logic is_empty;
   logic full;
   logic do_pop;

   assign is_empty = count == '0;
   assign full = count == (PTR_W+1)'(`TQ_DEPTH);
   assign do_pop = pop && !is_empty;

   always_ff @(posedge clk) begin
      if (push)
         entries[wr_ptr] <= wdata;
      if (do_pop)
         rdata <= entries[rd_ptr];  // Head, held for the response cycle
   end

   always_ff @(posedge clk) begin
      if (!rstn) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count <= '0;
         rvalid <= 1'b0;
         credit <= 1'b0;
         empty <= 1'b0;
      end else begin
         rvalid <= pop;
         credit <= do_pop;  // Slot freed
         empty <= is_empty;
         if (push)
            wr_ptr <= wr_ptr + 1'b1;
         if (do_pop)
            rd_ptr <= rd_ptr + 1'b1;
         case ({push, do_pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
      end
   end

   // Bridge credits must keep pushes off a full queue
   a_no_push_full: assert property (@(posedge clk) disable iff (!rstn)
      push |-> !full);

endmodule

`default_nettype wire

// ==== hw/host_reg_bridge.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "tile_ctrl_defines.svh"

module host_reg_bridge (
   input  wire                                  clk,
   input  wire                                  rstn,

   input  wire                                  host_awvalid,
   output logic                                 host_awready,
   input  wire [`ADDR_W-1:0]                    host_awaddr,
   input  wire                                  host_wvalid,
   output logic                                 host_wready,
   input  wire [`DATA_W-1:0]                    host_wdata,
   output logic                                 host_bvalid,
   input  wire                                  host_bready,
   output tile_ctrl_pkg::resp_t                 host_bresp,
   input  wire                                  host_arvalid,
   output logic                                 host_arready,
   input  wire [`ADDR_W-1:0]                    host_araddr,
   output logic                                 host_rvalid,
   input  wire                                  host_rready,
   output logic [`DATA_W-1:0]                   host_rdata,
   output tile_ctrl_pkg::resp_t                 host_rresp,

   output logic [`REG_AW-1:0]                   reg_waddr,
   output logic [`DATA_W-1:0]                   reg_wdata,
   output logic [`N_CORES-1:0]                  reg_wvalid,
   output logic [`REG_AW-1:0]                   reg_araddr,
   output logic [`N_CORES-1:0]                  reg_arvalid,
   input  wire [`N_CORES-1:0]                   reg_rvalid,
   input  wire [`N_CORES-1:0][`DATA_W-1:0]      reg_rdata,

   output logic                                 task_push,
   output tile_ctrl_pkg::task_t                 task_wdata,
   input  wire                                  task_credit,
   output logic                                 task_pop,
   input  wire                                  task_rvalid,
   input  wire tile_ctrl_pkg::task_t            task_rdata,
   input  wire                                  task_empty,

   output logic                                 mem_req,
   output logic                                 mem_we,
   output logic [`MEM_AW-1:0]                   mem_addr,
   output logic [`DATA_W-1:0]                   mem_wdata,
   input  wire                                  mem_rvalid,
   input  wire [`DATA_W-1:0]                    mem_rdata,

   input  wire [`N_CORES-1:0]                   core_done
);

   import tile_ctrl_pkg::*;

   localparam int CREDIT_W = $clog2(`TQ_DEPTH) + 1;

   bridge_state_t state;
   local_reg_t reg_sel;
   resp_t resp;

   logic [`ADDR_W-1:0] addr;
   logic [`DATA_W-1:0] data;
   logic wr_txn;
   logic is_local;
   logic [`N_CORES-1:0] core_mask;
   logic [`DATA_W-1:0] core_rdata;
   logic [CREDIT_W-1:0] credit;

   logic [1:0] stg_ttype;
   logic [31:0] stg_locale;
   logic [31:0] stg_args;
   logic [`MEM_AW-1:0] mem_addr_q;

   logic [63:0] cycle;
   logic [31:0] mem_t0;
   logic [31:0] last_mem_latency;

   // Broadcast is honoured for writes only
   function automatic logic [`N_CORES-1:0] decode_cores(input logic [7:0] id, input logic wr);
      logic [`N_CORES-1:0] m;
      m = '0;
      if (wr && id == `ID_ALL_CORES)
         m = '1;
      else if (id >= 8'd1 && id <= 8'(`N_CORES))
         m = {{(`N_CORES-1){1'b0}}, 1'b1} << (id - 8'd1);
      return m;
   endfunction

   assign is_local = addr[15:8] == `ID_LOCAL;
   assign reg_sel = local_reg_t'(addr[7:0]);

   always_comb begin
      core_rdata = '0;
      for (int i = 0; i < `N_CORES; i++) begin
         if (core_mask[i])
            core_rdata |= reg_rdata[i];
      end
   end

   always_ff @(posedge clk) begin
      if (!rstn) begin
         state <= IDLE;
      end else begin
         case (state)
            IDLE: begin
               resp <= OKAY;
               if (host_awvalid) begin  // Writes win over reads
                  state <= WAIT_W;
                  wr_txn <= 1'b1;
                  addr <= host_awaddr;
                  core_mask <= decode_cores(host_awaddr[15:8], 1'b1);
               end else if (host_arvalid) begin
                  state <= SEND_AR;
                  wr_txn <= 1'b0;
                  addr <= host_araddr;
                  core_mask <= decode_cores(host_araddr[15:8], 1'b0);
               end
            end
            WAIT_W: begin
               if (host_wvalid) begin
                  state <= SEND_W;
                  data <= host_wdata;
               end
            end
            SEND_W: begin
               state <= SEND_B;
               if (is_local) begin
                  case (reg_sel)
                     TASK_ENQ: begin
                        if (credit == '0)
                           resp <= SLVERR;  // Dropped, queue full
                     end
                     TASK_TTYPE:  stg_ttype <= data[1:0];
                     TASK_LOCALE: stg_locale <= data;
                     TASK_ARGS:   stg_args <= data;
                     MEM_ADDR:    mem_addr_q <= data[`MEM_AW-1:0];
                     MEM_ACCESS:  state <= WAIT_MEM;
                     default: ;
                  endcase
               end
            end
            WAIT_MEM: begin
               if (mem_rvalid) begin
                  state <= wr_txn ? SEND_B : SEND_R;
                  data <= mem_rdata;
               end
            end
            SEND_B: begin
               if (host_bready)
                  state <= IDLE;
            end
            SEND_AR: begin
               state <= (is_local && reg_sel == MEM_ACCESS) ? WAIT_MEM : WAIT_R;
            end
            WAIT_R: begin
               state <= SEND_R;
               if (|core_mask) begin
                  if (|(reg_rvalid & core_mask))
                     data <= core_rdata;
                  else
                     state <= WAIT_R;
               end else if (!is_local) begin
                  data <= '0;
                  resp <= SLVERR;
               end else begin
                  case (reg_sel)
                     TASK_ENQ: begin
                        if (!task_rvalid) begin
                           state <= WAIT_R;
                        end else if (task_empty) begin
                           data <= '0;
                           resp <= SLVERR;
                        end else begin
                           data <= task_rdata.ts;
                           stg_locale <= task_rdata.locale;
                           stg_args <= task_rdata.args;
                        end
                     end
                     TASK_TTYPE:       data <= `DATA_W'(stg_ttype);
                     TASK_LOCALE:      data <= stg_locale;
                     TASK_ARGS:        data <= stg_args;
                     MEM_ADDR:         data <= `DATA_W'(mem_addr_q);
                     CYCLE_LSB:        data <= cycle[31:0];
                     CYCLE_MSB:        data <= cycle[63:32];
                     LAST_MEM_LATENCY: data <= last_mem_latency;
                     PARAM_N_CORES:    data <= `DATA_W'(`N_CORES);
                     DONE:             data <= `DATA_W'(core_done);
                     default: begin
                        data <= '0;
                        resp <= SLVERR;
                     end
                  endcase
               end
            end
            SEND_R: begin
               if (host_rready)
                  state <= IDLE;
            end
            default: state <= IDLE;
         endcase
      end
   end

   // One credit per free queue entry
   always_ff @(posedge clk) begin
      if (!rstn)
         credit <= CREDIT_W'(`TQ_DEPTH);
      else if (task_push && !task_credit)
         credit <= credit - 1'b1;
      else if (task_credit && !task_push)
         credit <= credit + 1'b1;
   end

   always_ff @(posedge clk) begin
      if (!rstn)
         cycle <= '0;
      else
         cycle <= cycle + 64'd1;
   end

   always_ff @(posedge clk) begin
      if (mem_req)
         mem_t0 <= cycle[31:0];
      if (mem_rvalid)
         last_mem_latency <= cycle[31:0] - mem_t0;
   end

   assign host_awready = state == IDLE;
   assign host_arready = state == IDLE;
   assign host_wready = state == WAIT_W;
   assign host_bvalid = state == SEND_B;
   assign host_bresp = resp;
   assign host_rvalid = state == SEND_R;
   assign host_rdata = data;
   assign host_rresp = resp;

   assign reg_waddr = addr[7:0];
   assign reg_wdata = data;
   assign reg_wvalid = core_mask & {`N_CORES{state == SEND_W}};
   assign reg_araddr = addr[7:0];
   assign reg_arvalid = core_mask & {`N_CORES{state == SEND_AR}};

   assign task_push = state == SEND_W && is_local && reg_sel == TASK_ENQ && credit != '0;
   assign task_wdata = '{ttype: stg_ttype, locale: stg_locale, args: stg_args, ts: data};
   assign task_pop = state == SEND_AR && is_local && reg_sel == TASK_ENQ;

   assign mem_req = is_local && reg_sel == MEM_ACCESS && (state == SEND_W || state == SEND_AR);
   assign mem_we = state == SEND_W;
   assign mem_addr = mem_addr_q;
   assign mem_wdata = data;

   // Returned credits can never outnumber the queue entries
   a_credit_max: assert property (@(posedge clk) disable iff (!rstn)
      credit <= CREDIT_W'(`TQ_DEPTH));

   a_arvalid_onehot: assert property (@(posedge clk) disable iff (!rstn)
      $onehot0(reg_arvalid));

   // An enqueue refused for lack of credit never reaches the queue
   a_push_credit: assert property (@(posedge clk) disable iff (!rstn)
      task_push |=> host_bresp == OKAY);

endmodule

`default_nettype wire

// ==== hw/tile_ctrl_top.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "tile_ctrl_defines.svh"

module tile_ctrl_top (
   input  wire                  clk,
   input  wire                  rstn,
   input  wire                  host_awvalid,
   output logic                 host_awready,
   input  wire [`ADDR_W-1:0]    host_awaddr,
   input  wire                  host_wvalid,
   output logic                 host_wready,
   input  wire [`DATA_W-1:0]    host_wdata,
   output logic                 host_bvalid,
   input  wire                  host_bready,
   output tile_ctrl_pkg::resp_t host_bresp,
   input  wire                  host_arvalid,
   output logic                 host_arready,
   input  wire [`ADDR_W-1:0]    host_araddr,
   output logic                 host_rvalid,
   input  wire                  host_rready,
   output logic [`DATA_W-1:0]   host_rdata,
   output tile_ctrl_pkg::resp_t host_rresp
);

   import tile_ctrl_pkg::*;

   logic [`REG_AW-1:0] reg_waddr;
   logic [`DATA_W-1:0] reg_wdata;
   logic [`N_CORES-1:0] reg_wvalid;
   logic [`REG_AW-1:0] reg_araddr;
   logic [`N_CORES-1:0] reg_arvalid;
   logic [`N_CORES-1:0] reg_rvalid;
   logic [`N_CORES-1:0][`DATA_W-1:0] reg_rdata;
   logic [`N_CORES-1:0] core_done;

   logic task_push;
   task_t task_wdata;
   logic task_credit;
   logic task_pop;
   logic task_rvalid;
   task_t task_rdata;
   logic task_empty;

   logic mem_req;
   logic mem_we;
   logic [`MEM_AW-1:0] mem_addr;
   logic [`DATA_W-1:0] mem_wdata;
   logic mem_rvalid;
   logic [`DATA_W-1:0] mem_rdata;

   host_reg_bridge u_bridge (
      .clk, .rstn,
      .host_awvalid, .host_awready, .host_awaddr,
      .host_wvalid, .host_wready, .host_wdata,
      .host_bvalid, .host_bready, .host_bresp,
      .host_arvalid, .host_arready, .host_araddr,
      .host_rvalid, .host_rready, .host_rdata, .host_rresp,
      .reg_waddr, .reg_wdata, .reg_wvalid,
      .reg_araddr, .reg_arvalid, .reg_rvalid, .reg_rdata,
      .task_push, .task_wdata, .task_credit,
      .task_pop, .task_rvalid, .task_rdata, .task_empty,
      .mem_req, .mem_we, .mem_addr, .mem_wdata, .mem_rvalid, .mem_rdata,
      .core_done
   );

   task_queue u_task_queue (
      .clk, .rstn,
      .push   (task_push),
      .wdata  (task_wdata),
      .pop    (task_pop),
      .credit (task_credit),
      .rvalid (task_rvalid),
      .rdata  (task_rdata),
      .empty  (task_empty)
   );

   scratch_mem u_scratch_mem (
      .clk, .rstn,
      .req    (mem_req),
      .we     (mem_we),
      .addr   (mem_addr),
      .wdata  (mem_wdata),
      .rvalid (mem_rvalid),
      .rdata  (mem_rdata)
   );

   // Core target ids start at 1
   for (genvar i = 0; i < `N_CORES; i++) begin : g_core
      core_csr #(
         .CORE_IDX(i + 1)
      ) u_core_csr (
         .clk, .rstn,
         .wvalid  (reg_wvalid[i]),
         .waddr   (reg_waddr),
         .wdata   (reg_wdata),
         .arvalid (reg_arvalid[i]),
         .araddr  (reg_araddr),
         .rvalid  (reg_rvalid[i]),
         .rdata   (reg_rdata[i]),
         .done    (core_done[i])
      );
   end

endmodule

`default_nettype wire

// ==== tb/tile_ctrl_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "tile_ctrl_defines.svh"

module tile_ctrl_tb;

   import tile_ctrl_pkg::*;

   localparam int N_CORE_OPS = 100;
   localparam int N_DONE_OPS = 30;
   localparam int N_TASK_OPS = 80;
   localparam int N_MEM_OPS = 80;
   localparam int N_CYCLE_READS = 20;
   // Upper bound on host transactions, fill and drain included
   localparam int N_TXN = 3 * N_CORE_OPS + 3 * N_DONE_OPS + 4 * N_TASK_OPS
                          + 3 * N_MEM_OPS + N_CYCLE_READS + 100;
   localparam int WATCHDOG_NS = N_TXN * 40 * 20 + 5000;

   logic clk = 1'b0;
   logic rstn;
   logic host_awvalid;
   logic host_awready;
   logic [`ADDR_W-1:0] host_awaddr;
   logic host_wvalid;
   logic host_wready;
   logic [`DATA_W-1:0] host_wdata;
   logic host_bvalid;
   logic host_bready;
   resp_t host_bresp;
   logic host_arvalid;
   logic host_arready;
   logic [`ADDR_W-1:0] host_araddr;
   logic host_rvalid;
   logic host_rready;
   logic [`DATA_W-1:0] host_rdata;
   resp_t host_rresp;

   // Reference model
   logic [31:0] m_scratch [`N_CORES];
   logic [31:0] m_config [`N_CORES];
   logic [`N_CORES-1:0] m_done;
   task_t m_tq [`TQ_DEPTH];
   int m_tq_head;
   int m_tq_count;
   logic [31:0] m_mem [`MEM_WORDS];
   logic [7:0] m_written [$];

   tile_ctrl_top DUT (
      .clk, .rstn,
      .host_awvalid, .host_awready, .host_awaddr,
      .host_wvalid, .host_wready, .host_wdata,
      .host_bvalid, .host_bready, .host_bresp,
      .host_arvalid, .host_arready, .host_araddr,
      .host_rvalid, .host_rready, .host_rdata, .host_rresp
   );

   always #10 clk = ~clk;

   task automatic end_with_failure(input string why);
      $display("%s", why);
      $display("FAIL: see errors above");
      $fatal(1, "Stopped at the first error");
   endtask

   initial begin
      #(WATCHDOG_NS);
      end_with_failure($sformatf("Timeout: run did not finish within %0d ns", WATCHDOG_NS));
   end

   task automatic check_data(input string name, input logic [`DATA_W-1:0] got,
                             input logic [`DATA_W-1:0] exp);
      if (got !== exp)
         end_with_failure($sformatf("[FAIL] t=%0t %s: got 0x%h, expected 0x%h",
                                    $time, name, got, exp));
   endtask

   task automatic check_resp(input string name, input resp_t got, input resp_t exp);
      if (got !== exp)
         end_with_failure($sformatf("[FAIL] t=%0t %s: got %s (%b), expected %s",
                                    $time, name, got.name(), got, exp.name()));
   endtask

   task automatic check_task(input string name, input task_t got, input task_t exp);
      if (got.ts !== exp.ts || got.locale !== exp.locale || got.args !== exp.args)
         end_with_failure($sformatf({"[FAIL] t=%0t %s: got ts %h locale %h args %h, ",
                                     "expected ts %h locale %h args %h"}, $time, name,
                                    got.ts, got.locale, got.args,
                                    exp.ts, exp.locale, exp.args));
   endtask

   // Random ready stalls; the response must stay up and go away once taken
   task automatic accept_response(input logic is_read);
      int stall;
      stall = $urandom_range(0, 3);
      repeat (stall) begin
         @(negedge clk);
         if (is_read ? !host_rvalid : !host_bvalid)
            end_with_failure("Host response was dropped during a ready stall");
      end
      @(posedge clk);
      if (is_read)
         host_rready <= 1'b1;
      else
         host_bready <= 1'b1;
      @(posedge clk);  // Handshake
      host_rready <= 1'b0;
      host_bready <= 1'b0;
      @(negedge clk);
      if (host_bvalid || host_rvalid)
         end_with_failure("Host response still valid after its handshake");
   endtask

   task automatic host_write(input logic [15:0] addr, input logic [31:0] d,
                             output resp_t resp);
      @(posedge clk);
      host_awvalid <= 1'b1;
      host_awaddr <= addr;
      do @(negedge clk); while (!host_awready);
      @(posedge clk);
      host_awvalid <= 1'b0;
      host_wvalid <= 1'b1;
      host_wdata <= d;
      do @(negedge clk); while (!host_wready);
      @(posedge clk);
      host_wvalid <= 1'b0;
      do @(negedge clk); while (!host_bvalid);
      resp = host_bresp;
      accept_response(1'b0);
   endtask

   task automatic host_read(input logic [15:0] addr, output logic [31:0] d,
                            output resp_t resp);
      @(posedge clk);
      host_arvalid <= 1'b1;
      host_araddr <= addr;
      do @(negedge clk); while (!host_arready);
      @(posedge clk);
      host_arvalid <= 1'b0;
      do @(negedge clk); while (!host_rvalid);
      d = host_rdata;
      resp = host_rresp;
      accept_response(1'b1);
   endtask

   task automatic write_expect(input logic [7:0] id, input logic [7:0] r,
                               input logic [31:0] d, input resp_t exp_resp);
      resp_t resp;
      host_write({id, r}, d, resp);
      check_resp($sformatf("host_bresp @%h", {id, r}), resp, exp_resp);
   endtask

   task automatic read_expect(input logic [7:0] id, input logic [7:0] r,
                              input logic [31:0] exp_data, input resp_t exp_resp);
      resp_t resp;
      logic [31:0] d;
      host_read({id, r}, d, resp);
      check_resp($sformatf("host_rresp @%h", {id, r}), resp, exp_resp);
      check_data($sformatf("host_rdata @%h", {id, r}), d, exp_data);
   endtask

   task automatic model_core_write(input int c, input core_reg_t r, input logic [31:0] d);
      case (r)
         CORE_SCRATCH: m_scratch[c] = d;
         CORE_CONFIG:  m_config[c] = d;
         CORE_DONE:    m_done[c] = d[0];
         default: ;
      endcase
   endtask

   function automatic logic [31:0] core_model_value(input int c, input core_reg_t r);
      case (r)
         CORE_SCRATCH: return m_scratch[c];
         CORE_CONFIG:  return m_config[c];
         CORE_DONE:    return 32'(m_done[c]);
         CORE_INDEX:   return 32'(c + 1);
         default:      return '0;
      endcase
   endfunction

   task automatic run_core_tests;
      logic [7:0] id;
      logic [31:0] d;
      int c;
      core_reg_t r;
      for (int n = 0; n < N_CORE_OPS; n++) begin
         c = $urandom_range(0, `N_CORES - 1);
         d = $urandom;
         r = ($urandom_range(0, 1) == 0) ? CORE_SCRATCH : CORE_CONFIG;
         case ($urandom_range(0, 5))
            0: begin
               write_expect(`ID_ALL_CORES, r, d, OKAY);
               for (int k = 0; k < `N_CORES; k++)
                  model_core_write(k, r, d);
            end
            1: begin
               write_expect(8'(c + 1), r, d, OKAY);
               model_core_write(c, r, d);
            end
            2, 3: read_expect(8'(c + 1), r, core_model_value(c, r), OKAY);
            4: read_expect(8'(c + 1), CORE_INDEX, core_model_value(c, CORE_INDEX), OKAY);
            default: begin  // Nobody home
               id = 8'($urandom_range(`N_CORES + 1, 8'hFE));
               write_expect(id, r, d, OKAY);
               read_expect(id, r, '0, SLVERR);
               read_expect(`ID_ALL_CORES, r, '0, SLVERR);
               read_expect(`ID_LOCAL, 8'($urandom_range(8'h0B, 8'hFF)), '0, SLVERR);
            end
         endcase
      end
   endtask

   task automatic run_done_tests;
      logic [31:0] d;
      int c;
      for (int n = 0; n < N_DONE_OPS; n++) begin
         c = $urandom_range(0, `N_CORES - 1);
         d = $urandom;
         if ($urandom_range(0, 3) == 0) begin
            write_expect(`ID_ALL_CORES, CORE_DONE, d, OKAY);
            for (int k = 0; k < `N_CORES; k++)
               model_core_write(k, CORE_DONE, d);
         end else begin
            write_expect(8'(c + 1), CORE_DONE, d, OKAY);
            model_core_write(c, CORE_DONE, d);
         end
         read_expect(`ID_LOCAL, DONE, 32'(m_done), OKAY);
         read_expect(8'(c + 1), CORE_DONE, core_model_value(c, CORE_DONE), OKAY);
      end
      read_expect(`ID_LOCAL, PARAM_N_CORES, 32'(`N_CORES), OKAY);
   endtask

   function automatic task_t random_task();
      task_t t;
      t.ttype = 2'($urandom);
      t.locale = $urandom;
      t.args = $urandom;
      t.ts = $urandom;
      return t;
   endfunction

   task automatic enqueue_task(input task_t t);
      write_expect(`ID_LOCAL, TASK_TTYPE, 32'(t.ttype), OKAY);
      write_expect(`ID_LOCAL, TASK_LOCALE, t.locale, OKAY);
      write_expect(`ID_LOCAL, TASK_ARGS, t.args, OKAY);
      if (m_tq_count < `TQ_DEPTH) begin
         write_expect(`ID_LOCAL, TASK_ENQ, t.ts, OKAY);
         m_tq[(m_tq_head + m_tq_count) % `TQ_DEPTH] = t;
         m_tq_count++;
      end else begin
         write_expect(`ID_LOCAL, TASK_ENQ, t.ts, SLVERR);  // No credit left
      end
   endtask

   task automatic dequeue_task;
      task_t got;
      resp_t resp;
      logic [31:0] d;
      host_read({`ID_LOCAL, TASK_ENQ}, d, resp);
      if (m_tq_count == 0) begin
         check_resp("host_rresp dequeue", resp, SLVERR);
         check_data("host_rdata dequeue", d, '0);
      end else begin
         check_resp("host_rresp dequeue", resp, OKAY);
         got = '0;
         got.ts = d;
         host_read({`ID_LOCAL, TASK_LOCALE}, d, resp);
         check_resp("host_rresp TASK_LOCALE", resp, OKAY);
         got.locale = d;
         host_read({`ID_LOCAL, TASK_ARGS}, d, resp);
         check_resp("host_rresp TASK_ARGS", resp, OKAY);
         got.args = d;
         check_task("dequeued task", got, m_tq[m_tq_head]);
         m_tq_head = (m_tq_head + 1) % `TQ_DEPTH;
         m_tq_count--;
      end
   endtask

   task automatic run_task_tests;
      for (int n = 0; n < N_TASK_OPS; n++) begin
         if ($urandom_range(0, 2) != 0)
            enqueue_task(random_task());
         else
            dequeue_task();
      end
      // Fill, one past full, then drain past empty
      repeat (`TQ_DEPTH - m_tq_count + 1) enqueue_task(random_task());
      repeat (`TQ_DEPTH + 1) dequeue_task();
   endtask

   task automatic run_mem_tests;
      logic [7:0] a;
      logic [31:0] d;
      for (int n = 0; n < N_MEM_OPS; n++) begin
         if (m_written.size() == 0 || $urandom_range(0, 1) == 0) begin
            a = 8'($urandom);
            d = $urandom;
            write_expect(`ID_LOCAL, MEM_ADDR, 32'(a), OKAY);
            write_expect(`ID_LOCAL, MEM_ACCESS, d, OKAY);
            m_mem[a] = d;
            m_written.push_back(a);
         end else begin
            a = m_written[$urandom_range(0, m_written.size() - 1)];
            write_expect(`ID_LOCAL, MEM_ADDR, 32'(a), OKAY);
            read_expect(`ID_LOCAL, MEM_ADDR, 32'(a), OKAY);
            read_expect(`ID_LOCAL, MEM_ACCESS, m_mem[a], OKAY);
         end
      end
      read_expect(`ID_LOCAL, LAST_MEM_LATENCY, 32'(`MEM_LATENCY), OKAY);
   endtask

   task automatic run_cycle_tests;
      logic [31:0] prev;
      logic [31:0] cur;
      resp_t resp;
      host_read({`ID_LOCAL, CYCLE_LSB}, prev, resp);
      for (int n = 0; n < N_CYCLE_READS; n++) begin
         host_read({`ID_LOCAL, CYCLE_LSB}, cur, resp);
         check_resp("host_rresp CYCLE_LSB", resp, OKAY);
         if (cur <= prev)
            end_with_failure($sformatf("[FAIL] t=%0t host_rdata CYCLE_LSB: got %0d, expected > %0d",
                                       $time, cur, prev));
         prev = cur;
      end
      read_expect(`ID_LOCAL, CYCLE_MSB, '0, OKAY);  // Short run
   endtask

   initial begin
      void'($urandom(32'h9824_5b1a));
      rstn = 1'b0;
      host_awvalid = 1'b0;
      host_awaddr = '0;
      host_wvalid = 1'b0;
      host_wdata = '0;
      host_bready = 1'b0;
      host_arvalid = 1'b0;
      host_araddr = '0;
      host_rready = 1'b0;
      for (int c = 0; c < `N_CORES; c++) begin
         m_scratch[c] = '0;
         m_config[c] = '0;
      end
      m_done = '0;
      m_tq_head = 0;
      m_tq_count = 0;
      repeat (3) @(posedge clk);
      rstn <= 1'b1;
      @(negedge clk);
      if (!host_awready || !host_arready || host_bvalid || host_rvalid)
         end_with_failure("Host port is not idle after reset");
      run_core_tests();
      run_done_tests();
      run_task_tests();
      run_mem_tests();
      run_cycle_tests();
      $display("PASS: all tests");
      $finish;
   end

endmodule

`default_nettype wire

// ==== tile_ctrl.f ====
+incdir+include
hw/tile_ctrl_pkg.sv
hw/core_csr.sv
hw/scratch_mem.sv
hw/task_queue.sv
hw/host_reg_bridge.sv
hw/tile_ctrl_top.sv
tb/tile_ctrl_tb.sv

// ==== Makefile ====
VERILATOR  ?= verilator
FILELIST   := tile_ctrl.f
TOP_RTL    := tile_ctrl_top
TOP_TB     := tile_ctrl_tb
LINT_FLAGS := --lint-only --timing
SIM_FLAGS  := --binary --timing -j 0
BUILD_DIR  := obj_dir
LOG        := sim.log
PASS_MSG   := PASS: all tests
FAIL_MSG   := FAIL: see errors above

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP_RTL)

sim:
	$(VERILATOR) $(SIM_FLAGS) -f $(FILELIST) --top-module $(TOP_TB) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP_TB) 2>&1 | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG) || ! grep -q "$(PASS_MSG)" $(LOG); then \
		echo "Simulation failed, see $(LOG)"; exit 1; fi
	@echo "Simulation passed"

clean:
	rm -rf $(BUILD_DIR) $(LOG)
